// ==== decode_issue.f ====
hdl/issue_pkg.sv
hdl/issue_ifs.sv
hdl/inst_decode.sv
hdl/operand_bypass.sv
hdl/issue_ctrl.sv
hdl/rs_dispatch.sv
hdl/decode_issue_top.sv
tests/decode_issue_asserts.sv
tests/tb_decode_issue.sv

// ==== Makefile ====
TOP = tb_decode_issue

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f decode_issue.f -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_decode_issue.sv ====
module tb_decode_issue;

    localparam int TAG_W      = 3;
    localparam int NTAGS      = 1 << TAG_W;
    localparam int XLEN       = issue_pkg::XLEN;
    localparam int RA_W       = issue_pkg::REG_ADDR_W;
    localparam int N_CYCLES   = 2000;
    localparam int MAX_CYCLES = 5000;

    logic                  clk, rst, i_valid, i_alu_ready, i_cmp_ready;
    logic [XLEN-1:0]       i_inst, i_pc, i_reg_vj, i_reg_vk;
    logic [TAG_W-1:0]      i_reg_qj, i_reg_qk, i_rob_free_tag;
    logic [NTAGS-1:0]      i_rob_ready;
    logic [NTAGS*XLEN-1:0] i_rob_vals;
    logic                  o_shift, o_load_tag, o_rob_valid, o_alu_valid, o_cmp_valid;
    logic [RA_W-1:0]       o_rs1, o_rs2, o_rd_out, o_rob_dest;
    logic [TAG_W-1:0]      o_tag_out, o_alu_qj, o_alu_qk, o_alu_dest;
    logic [TAG_W-1:0]      o_cmp_qj, o_cmp_qk, o_cmp_dest;
    logic [2:0]            o_alu_op, o_cmp_op;
    logic [XLEN-1:0]       o_alu_vj, o_alu_vk, o_cmp_vj, o_cmp_vk;

    logic [31:0]      lfsr;
    int               errors, n_alu, n_cmp, n_fwd, n_upper, n_drop;
    // current stimulus.
    logic [XLEN-1:0]  s_inst, s_pc, s_vj, s_vk;
    logic             s_valid, s_alu_rdy, s_cmp_rdy;
    logic [TAG_W-1:0] s_free, s_qj, s_qk;
    logic [NTAGS-1:0] s_rob_rdy;
    logic [XLEN-1:0]  s_rob_val [NTAGS];
    // model view of the instruction in flight.
    logic             m_acc, m_cmp;
    logic [2:0]       m_op;
    logic [XLEN-1:0]  m_vj, m_vk;
    logic [TAG_W-1:0] m_qj, m_qk, m_dest;
    logic [RA_W-1:0]  m_rd;

    decode_issue_top #(.TAG_W(TAG_W)) decode_issue_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        int w;
        for (w = 0; w < MAX_CYCLES; w++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    // ==================================================
    // random source and checking
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1.
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int b;
        v = '0;
        for (b = 0; b < n; b++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ==================================================
    // stimulus and model
    // ==================================================
    task automatic drive_random();
        logic [31:0]           v;
        logic [31:0]           w;
        logic [NTAGS*XLEN-1:0] vals;
        int                    t;
        take_bits(32, w);
        take_bits(2, v);
        case (v[1:0])
            2'd0:    w[6:0] = issue_pkg::OPC_IMM;
            2'd1:    w[6:0] = issue_pkg::OPC_REG;
            2'd2:    w[6:0] = issue_pkg::OPC_LUI;
            default: w[6:0] = issue_pkg::OPC_AUIPC;
        endcase
        if (w[6:0] == issue_pkg::OPC_REG || (w[6:0] == issue_pkg::OPC_IMM && w[13:12] == 2'b01)) begin
            w[31:25] = {1'b0, w[30], 5'b00000};  // legal funct7 for shifts and reg ops.
        end
        take_bits(3, v);
        if (v[2:0] == 3'd0) begin
            w[11:7] = 5'd0;
        end else if (w[11:7] == 5'd0) begin
            w[11:7] = 5'd1;
        end
        s_inst = w;
        take_bits(32, v);
        s_pc = {v[31:2], 2'b00};
        take_bits(3, v);
        s_valid = (v[2:0] != 3'd0);
        take_bits(TAG_W, v);
        s_free = v[TAG_W-1:0];
        take_bits(2, v);
        s_alu_rdy = (v[1:0] != 2'd0);
        take_bits(2, v);
        s_cmp_rdy = (v[1:0] != 2'd0);
        take_bits(TAG_W, v);
        s_qj = v[TAG_W-1:0];
        take_bits(TAG_W, v);
        s_qk = v[TAG_W-1:0];
        take_bits(32, s_vj);
        take_bits(32, s_vk);
        take_bits(NTAGS, v);
        s_rob_rdy = v[NTAGS-1:0];
        for (t = 0; t < NTAGS; t++) begin
            take_bits(32, s_rob_val[t]);
            vals[t*XLEN +: XLEN] = s_rob_val[t];
        end
        i_inst         <= s_inst;
        i_pc           <= s_pc;
        i_valid        <= s_valid;
        i_rob_free_tag <= s_free;
        i_alu_ready    <= s_alu_rdy;
        i_cmp_ready    <= s_cmp_rdy;
        i_reg_qj       <= s_qj;
        i_reg_qk       <= s_qk;
        i_reg_vj       <= s_vj;
        i_reg_vk       <= s_vk;
        i_rob_ready    <= s_rob_rdy;
        i_rob_vals     <= vals;
    endtask

    task automatic run_model();
        logic [6:0] opc;
        logic [2:0] f3;
        logic       is_op, is_opi, is_lui, is_auipc, fwd_j, fwd_k;
        opc      = s_inst[6:0];
        f3       = s_inst[14:12];
        is_op    = (opc == 7'b0110011);
        is_opi   = (opc == 7'b0010011);
        is_lui   = (opc == 7'b0110111);
        is_auipc = (opc == 7'b0010111);
        m_rd     = s_inst[11:7];
        m_dest   = s_free;
        m_cmp    = (is_op || is_opi) && (f3 == 3'b010 || f3 == 3'b011);  // slt and sltu.
        m_acc    = s_valid && (is_op || is_opi || is_lui || is_auipc) && (m_rd != '0)
                   && (s_free != '0) && (m_cmp ? s_cmp_rdy : s_alu_rdy);
        fwd_j = (s_qj != '0) && s_rob_rdy[s_qj];
        fwd_k = (s_qk != '0) && s_rob_rdy[s_qk];
        m_vj  = fwd_j ? s_rob_val[s_qj] : s_vj;
        m_qj  = fwd_j ? '0 : s_qj;
        m_vk  = fwd_k ? s_rob_val[s_qk] : s_vk;
        m_qk  = fwd_k ? '0 : s_qk;
        if (is_opi) begin
            m_vk = {{20{s_inst[31]}}, s_inst[31:20]};
            m_qk = '0;
        end
        if (is_lui || is_auipc) begin
            m_vj = is_lui ? '0 : s_pc;
            m_qj = '0;
            m_vk = {s_inst[31:12], 12'h000};
            m_qk = '0;
        end
        if (m_cmp) begin
            m_op = (f3 == 3'b010) ? issue_pkg::CMP_LT : issue_pkg::CMP_LTU;
        end else if (is_lui || is_auipc) begin
            m_op = issue_pkg::ALU_ADD;
        end else begin
            case (f3)
                3'b000:  m_op = (is_op && s_inst[30]) ? issue_pkg::ALU_SUB : issue_pkg::ALU_ADD;
                3'b001:  m_op = issue_pkg::ALU_SLL;
                3'b100:  m_op = issue_pkg::ALU_XOR;
                3'b101:  m_op = s_inst[30] ? issue_pkg::ALU_SRA : issue_pkg::ALU_SRL;
                3'b110:  m_op = issue_pkg::ALU_OR;
                default: m_op = issue_pkg::ALU_AND;
            endcase
        end
        if (m_acc) begin
            n_alu   += int'(!m_cmp);
            n_cmp   += int'(m_cmp);
            n_upper += int'(is_lui || is_auipc);
            n_fwd   += int'((fwd_j && !is_lui && !is_auipc) || (fwd_k && is_op));
        end else begin
            n_drop++;
        end
    endtask

    // registered outputs, one cycle after the model saw the instruction.
    task automatic check_issue();
        check_value("alu valid", 32'(o_alu_valid), 32'(m_acc && !m_cmp));
        check_value("cmp valid", 32'(o_cmp_valid), 32'(m_acc && m_cmp));
        check_value("rob valid", 32'(o_rob_valid), 32'(m_acc));
        if (m_acc && !m_cmp) begin
            check_value("alu op", 32'(o_alu_op), 32'(m_op));
            check_value("alu vj", o_alu_vj, m_vj);
            check_value("alu vk", o_alu_vk, m_vk);
            check_value("alu qj", 32'(o_alu_qj), 32'(m_qj));
            check_value("alu qk", 32'(o_alu_qk), 32'(m_qk));
            check_value("alu dest", 32'(o_alu_dest), 32'(m_dest));
        end
        if (m_acc && m_cmp) begin
            check_value("cmp op", 32'(o_cmp_op), 32'(m_op));
            check_value("cmp vj", o_cmp_vj, m_vj);
            check_value("cmp vk", o_cmp_vk, m_vk);
            check_value("cmp qj", 32'(o_cmp_qj), 32'(m_qj));
            check_value("cmp qk", 32'(o_cmp_qk), 32'(m_qk));
            check_value("cmp dest", 32'(o_cmp_dest), 32'(m_dest));
        end
        if (m_acc) begin
            check_value("rob dest", 32'(o_rob_dest), 32'(m_rd));
        end
    endtask

    task automatic check_same_cycle();
        check_value("shift", 32'(o_shift), 32'(m_acc));
        check_value("load tag", 32'(o_load_tag), 32'(m_acc));
        check_value("rs1", 32'(o_rs1), 32'(s_inst[19:15]));
        check_value("rs2", 32'(o_rs2), 32'(s_inst[24:20]));
        if (m_acc) begin
            check_value("tag out", 32'(o_tag_out), 32'(s_free));
            check_value("rd out", 32'(o_rd_out), 32'(m_rd));
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin : main
        int cyc;
        lfsr           = 32'hd57e;
        errors         = 0;
        n_alu          = 0;
        n_cmp          = 0;
        n_fwd          = 0;
        n_upper        = 0;
        n_drop         = 0;
        m_acc          = 1'b0;
        m_cmp          = 1'b0;
        rst            = 1'b1;
        i_valid        = 1'b1;  // an issuable addi waits at the queue head.
        i_inst         = 32'h0000_0093;
        i_pc           = '0;
        i_reg_qj       = '0;
        i_reg_qk       = '0;
        i_reg_vj       = '0;
        i_reg_vk       = '0;
        i_rob_ready    = '0;
        i_rob_vals     = '0;
        i_rob_free_tag = TAG_W'(1);
        i_alu_ready    = 1'b1;
        i_cmp_ready    = 1'b1;
        repeat (3) @(posedge clk);
        rst     <= 1'b0;
        i_valid <= 1'b0;
        @(negedge clk);
        check_issue();  // reset kept it out of the stations.
        for (cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            check_issue();
            run_model();
            check_same_cycle();
        end
        @(posedge clk);
        i_valid <= 1'b0;
        @(negedge clk);
        check_issue();
        if (errors == 0 && n_alu > 0 && n_cmp > 0 && n_upper > 0 && n_fwd > 0) begin
            $display("alu %0d, cmp %0d, upper %0d, forwarded %0d, not issued %0d",
                     n_alu, n_cmp, n_upper, n_fwd, n_drop);
            $display("TESTBENCH PASSED");
        end else begin
            $display("errors seen or some issue kind never occurred");
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/decode_issue_asserts.sv ====
module decode_issue_asserts (
    input logic clk,
    input logic rst,
    input logic i_shift,
    input logic i_load_tag,
    input logic i_alu_valid,
    input logic i_cmp_valid,
    input logic i_rob_valid
);

    // ==================================================
    // station and rob valids
    // ==================================================
    a_one_station: assert property (@(posedge clk) disable iff (rst)
        !(i_alu_valid && i_cmp_valid))
        else $error("alu and compare stations written in the same cycle");

    a_rob_valid: assert property (@(posedge clk) disable iff (rst)
        i_rob_valid == (i_alu_valid || i_cmp_valid))
        else $error("rob valid does not follow the station valids");

    // ==================================================
    // queue side
    // ==================================================
    a_load_shift: assert property (@(posedge clk) disable iff (rst)
        i_load_tag |-> i_shift)
        else $error("tag write without a queue shift");

    a_shift_issue: assert property (@(posedge clk) disable iff (rst)
        (!rst && i_shift) |=> (i_alu_valid ^ i_cmp_valid))  // one station per issue.
        else $error("queue shift not followed by exactly one station write");

endmodule

bind decode_issue_top decode_issue_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .i_shift     (o_shift),
    .i_load_tag  (o_load_tag),
    .i_alu_valid (o_alu_valid),
    .i_cmp_valid (o_cmp_valid),
    .i_rob_valid (o_rob_valid)
);

// ==== hdl/decode_issue_top.sv ====
module decode_issue_top #(
    parameter int TAG_W = 3
) (
    input  logic                                   clk,
    input  logic                                   rst,
    // instruction queue
    input  logic                                   i_valid,
    input  logic [issue_pkg::XLEN-1:0]             i_inst,
    input  logic [issue_pkg::XLEN-1:0]             i_pc,
    output logic                                   o_shift,
    // register file
    output logic [issue_pkg::REG_ADDR_W-1:0]       o_rs1,
    output logic [issue_pkg::REG_ADDR_W-1:0]       o_rs2,
    input  logic [TAG_W-1:0]                       i_reg_qj,
    input  logic [TAG_W-1:0]                       i_reg_qk,
    input  logic [issue_pkg::XLEN-1:0]             i_reg_vj,
    input  logic [issue_pkg::XLEN-1:0]             i_reg_vk,
    output logic                                   o_load_tag,
    output logic [TAG_W-1:0]                       o_tag_out,
    output logic [issue_pkg::REG_ADDR_W-1:0]       o_rd_out,
    // rob
    input  logic [(1<<TAG_W)-1:0]                  i_rob_ready,
    input  logic [(1<<TAG_W)*issue_pkg::XLEN-1:0]  i_rob_vals,
    input  logic [TAG_W-1:0]                       i_rob_free_tag,
    output logic                                   o_rob_valid,
    output logic [issue_pkg::REG_ADDR_W-1:0]       o_rob_dest,
    // reservation stations
    input  logic                                   i_alu_ready,
    input  logic                                   i_cmp_ready,
    output logic                                   o_alu_valid,
    output issue_pkg::alu_op_e                     o_alu_op,
    output logic [issue_pkg::XLEN-1:0]             o_alu_vj,
    output logic [issue_pkg::XLEN-1:0]             o_alu_vk,
    output logic [TAG_W-1:0]                       o_alu_qj,
    output logic [TAG_W-1:0]                       o_alu_qk,
    output logic [TAG_W-1:0]                       o_alu_dest,
    output logic                                   o_cmp_valid,
    output issue_pkg::cmp_op_e                     o_cmp_op,
    output logic [issue_pkg::XLEN-1:0]             o_cmp_vj,
    output logic [issue_pkg::XLEN-1:0]             o_cmp_vk,
    output logic [TAG_W-1:0]                       o_cmp_qj,
    output logic [TAG_W-1:0]                       o_cmp_qk,
    output logic [TAG_W-1:0]                       o_cmp_dest
);
    logic [issue_pkg::REG_ADDR_W-1:0] rd;
    logic                             opc_ok;
    logic                             to_cmp;
    logic                             use_imm;
    logic                             zero_j;
    logic                             pc_j;
    logic [issue_pkg::XLEN-1:0]       imm;
    logic [issue_pkg::XLEN-1:0]       pc;
    issue_pkg::alu_op_e               alu_op;
    issue_pkg::cmp_op_e               cmp_op;

    operand_if #(.TAG_W(TAG_W)) opnd ();
    issue_if   #(.TAG_W(TAG_W)) req ();

    inst_decode u_decode (
        .i_inst    (i_inst),
        .i_pc      (i_pc),
        .o_rs1     (o_rs1),
        .o_rs2     (o_rs2),
        .o_rd      (rd),
        .o_opc_ok  (opc_ok),
        .o_to_cmp  (to_cmp),
        .o_use_imm (use_imm),
        .o_zero_j  (zero_j),
        .o_pc_j    (pc_j),
        .o_imm     (imm),
        .o_pc      (pc),
        .o_alu_op  (alu_op),
        .o_cmp_op  (cmp_op)
    );

    operand_bypass #(.TAG_W(TAG_W)) u_bypass (
        .i_reg_qj    (i_reg_qj),
        .i_reg_qk    (i_reg_qk),
        .i_reg_vj    (i_reg_vj),
        .i_reg_vk    (i_reg_vk),
        .i_rob_ready (i_rob_ready),
        .i_rob_vals  (i_rob_vals),
        .o_opnd      (opnd.src)
    );

    issue_ctrl #(.TAG_W(TAG_W)) u_ctrl (
        .i_valid     (i_valid),
        .i_opc_ok    (opc_ok),
        .i_to_cmp    (to_cmp),
        .i_use_imm   (use_imm),
        .i_zero_j    (zero_j),
        .i_pc_j      (pc_j),
        .i_imm       (imm),
        .i_pc        (pc),
        .i_rd        (rd),
        .i_alu_op    (alu_op),
        .i_cmp_op    (cmp_op),
        .i_opnd      (opnd.dst),
        .i_free_tag  (i_rob_free_tag),
        .i_alu_ready (i_alu_ready),
        .i_cmp_ready (i_cmp_ready),
        .o_shift     (o_shift),
        .o_load_tag  (o_load_tag),
        .o_tag_out   (o_tag_out),
        .o_rd_out    (o_rd_out),
        .o_req       (req.req)
    );

    rs_dispatch #(.TAG_W(TAG_W)) u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .i_req       (req.take),
        .o_alu_valid (o_alu_valid),
        .o_alu_op    (o_alu_op),
        .o_alu_vj    (o_alu_vj),
        .o_alu_vk    (o_alu_vk),
        .o_alu_qj    (o_alu_qj),
        .o_alu_qk    (o_alu_qk),
        .o_alu_dest  (o_alu_dest),
        .o_cmp_valid (o_cmp_valid),
        .o_cmp_op    (o_cmp_op),
        .o_cmp_vj    (o_cmp_vj),
        .o_cmp_vk    (o_cmp_vk),
        .o_cmp_qj    (o_cmp_qj),
        .o_cmp_qk    (o_cmp_qk),
        .o_cmp_dest  (o_cmp_dest),
        .o_rob_valid (o_rob_valid),
        .o_rob_dest  (o_rob_dest)
    );

endmodule

// ==== hdl/rs_dispatch.sv ====
module rs_dispatch #(
    parameter int TAG_W = 3
) (
    input  logic                             clk,
    input  logic                             rst,
    issue_if.take                            i_req,
    output logic                             o_alu_valid,
    output issue_pkg::alu_op_e               o_alu_op,
    output logic [issue_pkg::XLEN-1:0]       o_alu_vj,
    output logic [issue_pkg::XLEN-1:0]       o_alu_vk,
    output logic [TAG_W-1:0]                 o_alu_qj,
    output logic [TAG_W-1:0]                 o_alu_qk,
    output logic [TAG_W-1:0]                 o_alu_dest,
    output logic                             o_cmp_valid,
    output issue_pkg::cmp_op_e               o_cmp_op,
    output logic [issue_pkg::XLEN-1:0]       o_cmp_vj,
    output logic [issue_pkg::XLEN-1:0]       o_cmp_vk,
    output logic [TAG_W-1:0]                 o_cmp_qj,
    output logic [TAG_W-1:0]                 o_cmp_qk,
    output logic [TAG_W-1:0]                 o_cmp_dest,
    output logic                             o_rob_valid,
    output logic [issue_pkg::REG_ADDR_W-1:0] o_rob_dest
);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_alu_valid <= 1'b0;
            o_cmp_valid <= 1'b0;
        end else begin
            o_alu_valid <= i_req.to_alu;  // single cycle pulse.
            o_cmp_valid <= i_req.to_cmp;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.to_alu) begin
            o_alu_op   <= i_req.alu_op;
            o_alu_vj   <= i_req.vj;
            o_alu_vk   <= i_req.vk;
            o_alu_qj   <= i_req.qj;
            o_alu_qk   <= i_req.qk;
            o_alu_dest <= i_req.dest;
        end
        if (i_req.to_cmp) begin
            o_cmp_op   <= i_req.cmp_op;
            o_cmp_vj   <= i_req.vj;
            o_cmp_vk   <= i_req.vk;
            o_cmp_qj   <= i_req.qj;
            o_cmp_qk   <= i_req.qk;
            o_cmp_dest <= i_req.dest;
        end
        if (i_req.to_alu || i_req.to_cmp) begin
            o_rob_dest <= i_req.rd;  // rob entry names the target register.
        end
    end

    assign o_rob_valid = o_alu_valid | o_cmp_valid;

endmodule

// ==== hdl/issue_ctrl.sv ====
module issue_ctrl #(
    parameter int TAG_W = 3
) (
    input  logic                             i_valid,
    input  logic                             i_opc_ok,
    input  logic                             i_to_cmp,
    input  logic                             i_use_imm,
    input  logic                             i_zero_j,
    input  logic                             i_pc_j,
    input  logic [issue_pkg::XLEN-1:0]       i_imm,
    input  logic [issue_pkg::XLEN-1:0]       i_pc,
    input  logic [issue_pkg::REG_ADDR_W-1:0] i_rd,
    input  issue_pkg::alu_op_e               i_alu_op,
    input  issue_pkg::cmp_op_e               i_cmp_op,
    operand_if.dst                           i_opnd,
    input  logic [TAG_W-1:0]                 i_free_tag,
    input  logic                             i_alu_ready,
    input  logic                             i_cmp_ready,
    output logic                             o_shift,
    output logic                             o_load_tag,
    output logic [TAG_W-1:0]                 o_tag_out,
    output logic [issue_pkg::REG_ADDR_W-1:0] o_rd_out,
    issue_if.req                             o_req
);
    logic unit_ready;
    logic accept;
    logic const_j;

    // ==================================================
    // acceptance
    // ==================================================
    assign unit_ready = i_to_cmp ? i_cmp_ready : i_alu_ready;
    assign accept     = i_valid && i_opc_ok && (i_rd != '0) && (i_free_tag != '0) && unit_ready;

    assign o_shift    = accept;  // queue pops only on issue.
    assign o_load_tag = accept;
    assign o_tag_out  = accept ? i_free_tag : '0;
    assign o_rd_out   = accept ? i_rd : '0;

    // ==================================================
    // operand select
    // ==================================================
    assign const_j = i_zero_j || i_pc_j;

    assign o_req.vj = i_zero_j ? '0 : (i_pc_j ? i_pc : i_opnd.vj);
    assign o_req.qj = const_j ? '0 : i_opnd.qj;
    assign o_req.vk = i_use_imm ? i_imm : i_opnd.vk;
    assign o_req.qk = i_use_imm ? '0 : i_opnd.qk;

    assign o_req.to_alu = accept && !i_to_cmp;
    assign o_req.to_cmp = accept && i_to_cmp;
    assign o_req.alu_op = i_alu_op;
    assign o_req.cmp_op = i_cmp_op;
    assign o_req.dest   = i_free_tag;
    assign o_req.rd     = i_rd;

endmodule

// ==== hdl/operand_bypass.sv ====
module operand_bypass #(
    parameter int TAG_W = 3
) (
    input  logic [TAG_W-1:0]                       i_reg_qj,
    input  logic [TAG_W-1:0]                       i_reg_qk,
    input  logic [issue_pkg::XLEN-1:0]             i_reg_vj,
    input  logic [issue_pkg::XLEN-1:0]             i_reg_vk,
    input  logic [(1<<TAG_W)-1:0]                  i_rob_ready,
    input  logic [(1<<TAG_W)*issue_pkg::XLEN-1:0]  i_rob_vals,
    operand_if.src                                 o_opnd
);
    logic hit_j;
    logic hit_k;

    // a waiting source whose producer already sits ready in the rob.
    function automatic logic fwd_hit(input logic [TAG_W-1:0] q,
                                     input logic [(1<<TAG_W)-1:0] rdy);
        return (q != '0) && rdy[q];
    endfunction

    assign hit_j = fwd_hit(i_reg_qj, i_rob_ready);
    assign hit_k = fwd_hit(i_reg_qk, i_rob_ready);

    assign o_opnd.vj = hit_j ? i_rob_vals[i_reg_qj*issue_pkg::XLEN +: issue_pkg::XLEN] : i_reg_vj;
    assign o_opnd.vk = hit_k ? i_rob_vals[i_reg_qk*issue_pkg::XLEN +: issue_pkg::XLEN] : i_reg_vk;
    assign o_opnd.qj = hit_j ? '0 : i_reg_qj;  // forwarded value needs no tag.
    assign o_opnd.qk = hit_k ? '0 : i_reg_qk;

endmodule

// ==== hdl/inst_decode.sv ====
module inst_decode (
    input  issue_pkg::inst_u                 i_inst,
    input  logic [issue_pkg::XLEN-1:0]       i_pc,
    output logic [issue_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [issue_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [issue_pkg::REG_ADDR_W-1:0] o_rd,
    output logic                             o_opc_ok,
    output logic                             o_to_cmp,
    output logic                             o_use_imm,
    output logic                             o_zero_j,
    output logic                             o_pc_j,
    output logic [issue_pkg::XLEN-1:0]       o_imm,
    output logic [issue_pkg::XLEN-1:0]       o_pc,
    output issue_pkg::alu_op_e               o_alu_op,
    output issue_pkg::cmp_op_e               o_cmp_op
);
    issue_pkg::opcode_e         opcode;
    logic [2:0]                 funct3;
    logic                       f7_alt;
    logic [issue_pkg::XLEN-1:0] i_imm;
    logic [issue_pkg::XLEN-1:0] u_imm;
    logic                       is_slt;
    issue_pkg::alu_op_e         arith_op;

    assign opcode = issue_pkg::opcode_e'(i_inst.r_fmt.opcode);
    assign funct3 = i_inst.r_fmt.funct3;
    assign f7_alt = i_inst.r_fmt.funct7[5];
    assign o_rs1  = i_inst.r_fmt.rs1;
    assign o_rs2  = i_inst.r_fmt.rs2;
    assign o_rd   = i_inst.r_fmt.rd;
    assign o_pc   = i_pc;

    assign i_imm = {{20{i_inst.r_fmt.funct7[6]}}, i_inst.r_fmt.funct7, i_inst.r_fmt.rs2};
    assign u_imm = {i_inst.u_fmt.imm_hi, 12'h000};

    assign is_slt   = (funct3 == 3'b010) || (funct3 == 3'b011);
    assign o_cmp_op = (funct3 == 3'b011) ? issue_pkg::CMP_LTU : issue_pkg::CMP_LT;

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (f7_alt && opcode == issue_pkg::OPC_REG) ?
                                issue_pkg::ALU_SUB : issue_pkg::ALU_ADD;  // addi has no sub.
            3'b101:  arith_op = f7_alt ? issue_pkg::ALU_SRA : issue_pkg::ALU_SRL;
            default: arith_op = issue_pkg::alu_op_e'(funct3);
        endcase
    end

    always_comb begin
        o_opc_ok  = 1'b1;
        o_to_cmp  = 1'b0;
        o_use_imm = 1'b0;
        o_zero_j  = 1'b0;
        o_pc_j    = 1'b0;
        o_imm     = i_imm;
        o_alu_op  = arith_op;
        case (opcode)
            issue_pkg::OPC_IMM: begin
                o_use_imm = 1'b1;
                o_to_cmp  = is_slt;
            end
            issue_pkg::OPC_REG: o_to_cmp = is_slt;
            issue_pkg::OPC_LUI, issue_pkg::OPC_AUIPC: begin
                o_use_imm = 1'b1;
                o_imm     = u_imm;
                o_alu_op  = issue_pkg::ALU_ADD;  // 0 or pc plus upper imm.
                o_zero_j  = (opcode == issue_pkg::OPC_LUI);
                o_pc_j    = (opcode == issue_pkg::OPC_AUIPC);
            end
            default: o_opc_ok = 1'b0;
        endcase
    end

endmodule

// ==== hdl/issue_ifs.sv ====
// resolved source operands, bypass to issue control.
interface operand_if #(
    parameter int TAG_W = 3
);
    logic [issue_pkg::XLEN-1:0] vj;
    logic [issue_pkg::XLEN-1:0] vk;
    logic [TAG_W-1:0]           qj;
    logic [TAG_W-1:0]           qk;

    modport src (output vj, vk, qj, qk);
    modport dst (input vj, vk, qj, qk);
endinterface

// one issue request toward the station and rob registers.
interface issue_if #(
    parameter int TAG_W = 3
);
    logic                             to_alu;  // one cycle strobe.
    logic                             to_cmp;  // one cycle strobe.
    issue_pkg::alu_op_e               alu_op;
    issue_pkg::cmp_op_e               cmp_op;
    logic [issue_pkg::XLEN-1:0]       vj;
    logic [issue_pkg::XLEN-1:0]       vk;
    logic [TAG_W-1:0]                 qj;
    logic [TAG_W-1:0]                 qk;
    logic [TAG_W-1:0]                 dest;
    logic [issue_pkg::REG_ADDR_W-1:0] rd;

    modport req (
        output to_alu, to_cmp, alu_op, cmp_op, vj, vk, qj, qk, dest, rd
    );
    modport take (
        input to_alu, to_cmp, alu_op, cmp_op, vj, vk, qj, qk, dest, rd
    );
endinterface

// ==== hdl/issue_pkg.sv ====
package issue_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int XLEN       = 32;  // data word width.
    localparam int REG_ADDR_W = 5;   // architectural register number.
    localparam int OPC_W      = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int U_IMM_W    = 20;

    // ==================================================
    // encodings
    // ==================================================
    typedef enum logic [OPC_W-1:0] {
        OPC_IMM   = 7'b0010011,
        OPC_REG   = 7'b0110011,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111
    } opcode_e;

    // add, sll, xor, or and and line up with funct3.
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SLL = 3'b001,
        ALU_SRA = 3'b010,
        ALU_SUB = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SRL = 3'b101,
        ALU_OR  = 3'b110,
        ALU_AND = 3'b111
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_LT  = 3'b100,
        CMP_LTU = 3'b110
    } cmp_op_e;

    // ==================================================
    // instruction word
    // ==================================================
    typedef struct packed {
        logic [FUNCT7_W-1:0]   funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPC_W-1:0]      opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [U_IMM_W-1:0]    imm_hi;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPC_W-1:0]      opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;  // op and op-imm view.
        u_fmt_t u_fmt;  // lui and auipc view.
    } inst_u;

endpackage
